/* project.f */
+incdir+bench
hw/norm_pkg.sv
hw/norm_seq.sv
hw/rsqrt_seed_sel.sv
hw/norm_operand_sel.sv
hw/norm_result_capture.sv
hw/post_attn_norm_ctrl.sv
bench/tb_post_attn_norm_ctrl.sv

/* Bender.yml */
package:
  name: post_attn_norm_ctrl

sources:
  - hw/norm_pkg.sv
  - hw/norm_seq.sv
  - hw/rsqrt_seed_sel.sv
  - hw/norm_operand_sel.sv
  - hw/norm_result_capture.sv
  - hw/post_attn_norm_ctrl.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_post_attn_norm_ctrl.sv

/* bench/tb_norm_checks.svh */
// included inside the testbench module body and uses its DUT signals, expected state and seed
task automatic check_req(input string tag, input int cnt, input int lane,
                         input fma_lane_t got, input fma_lane_t exp);
    if (got !== exp) begin
        req_errs++;
        $display("mismatch at %0t: %s count %0d lane %0d request %h, expected %h",
                 $time, tag, cnt, lane, got, exp);
    end
endtask

task automatic check_val(input string tag, input int lane, input fp_t got, input fp_t exp);
    if (got !== exp) begin
        val_errs++;
        $display("mismatch at %0t: %s lane %0d is %h, expected %h", $time, tag, lane, got, exp);
    end
endtask

task automatic check_bit(input string tag, input logic got, input logic exp);
    if (got !== exp) begin
        bit_errs++;
        $display("mismatch at %0t: %s is %b, expected %b", $time, tag, got, exp);
    end
endtask

function automatic lane_vec_t rand_lanes();
    lane_vec_t v;
    for (int l = 0; l < NUM_LANES; l++) begin
        v[l] = 17'($random(rng_seed));
    end
    return v;
endfunction

function automatic fma_lane_t req_of(input fma_op_e op, input fp_t a, input fp_t b, input fp_t c);
    return '{op, a, b, c};
endfunction

// seed table with one branch per segment
function automatic rsqrt_seed_t seed_expect(input fp_t p);
    rsqrt_seed_t s;
    s.sub_a = {8'd7, p.exponent, 1'b0};
    s.fma_b = {8'd0, p.mantissa};
    if (p.exponent[0] && p.mantissa == 9'h080) begin
        s.sub_c = 17'h00a88;
        s.fma_a = 17'h00480;
        s.fma_c = 17'h00000;
    end else if (p.exponent[0] && p.mantissa < 9'h0b4) begin
        s.sub_c = 17'h008f0;
        s.fma_a = 17'h0073c;
        s.fma_c = 17'h006b0;
    end else if (p.exponent[0]) begin
        s.sub_c = 17'h008f0;
        s.fma_a = 17'h00518;
        s.fma_c = 17'h00694;
    end else if (p.mantissa < 9'h0b4) begin
        s.sub_c = 17'h00a80;
        s.fma_a = 17'h00976;
        s.fma_c = 17'h006f8;
    end else begin
        s.sub_c = 17'h00a80;
        s.fma_a = 17'h0075c;
        s.fma_c = 17'h006d1;
    end
    return s;
endfunction

function automatic fma_lane_t resid_expect(input int cnt, input int lane);
    int        i;
    int        j;
    int        rb;
    fma_lane_t r;
    i  = lane / ROW_LANES;
    j  = lane % ROW_LANES;
    rb = i * ROW_LANES; // first lane of the row
    r  = '0;
    case (cnt)
        0: r = req_of(OP_ADD, o_proj[lane], '0, z0[lane]);
        2: r = req_of(OP_MUL, fma_out[lane], fma_out[lane], '0);
        3: r = req_of(OP_MUL, res_m[lane], weight[j], '0);
        4: if (j >= 4) r = req_of(OP_ADD, fma_out[rb+2*(j-4)+1], '0, fma_out[rb+2*(j-4)]);
        6: if (j >= 6) r = req_of(OP_ADD, fma_out[rb+2*(j-6)+5], '0, fma_out[rb+2*(j-6)+4]);
        8: if (j == 7) r = req_of(OP_ADD, fma_out[rb+7], '0, fma_out[rb+6]);
        10: if (j == 7) r = req_of(OP_ADD, fma_out[rb+7], '0, psum_m[i]);
        17: r = req_of(OP_MUL, alpha_m[i], buffer_norm_in[lane], '0);
        default: ;
    endcase
    return r;
endfunction

function automatic fma_lane_t rsqrt_expect(input int cnt, input int lane);
    rsqrt_seed_t s;
    s = seed_expect(psum_m[lane / ROW_LANES]);
    if (lane % ROW_LANES != 0 || cnt > 1) begin
        return '0;
    end
    if (cnt == 0) begin
        return req_of(OP_SUB, s.sub_a, '0, s.sub_c);
    end
    return req_of(OP_FMA, s.fma_a, s.fma_b, s.fma_c);
endfunction

// returns on the rising edge that begins count 0
task automatic start_phase(input bit rsqrt);
    @(posedge clk);
    if (rsqrt) begin
        start_rsqrt <= 1'b1;
    end else begin
        start_residual <= 1'b1;
    end
    @(negedge clk);
    check_bit("busy before start edge", busy, 1'b0); // start not yet sampled
    @(posedge clk);
    start_rsqrt    <= 1'b0;
    start_residual <= 1'b0;
endtask

task automatic wait_idle(input string tag, input int high_cycles, input int expected);
    int n;
    n = high_cycles;
    @(negedge clk);
    while (busy === 1'b1 && n < expected + 8) begin
        n++;
        @(negedge clk);
    end
    if (busy !== 1'b0) begin
        other_errs++;
        $display("%s: busy did not drop within %0d cycles", tag, expected + 8);
    end else if (n != expected) begin
        bit_errs++;
        $display("mismatch at %0t: %s busy high for %0d cycles, expected %0d",
                 $time, tag, n, expected);
    end
endtask

task automatic buffer_check(input string tag);
    for (int l = 0; l < NUM_LANES; l++) begin
        check_val({tag, " buffer lower"}, l, buffer_norm_out.lower[l], buf_m.lower[l]);
        check_val({tag, " buffer upper"}, l, buffer_norm_out.upper[l], buf_m.upper[l]);
    end
endtask

task automatic resid_pass(input string tag, input bit force_root, input row_vec_t roots);
    lane_vec_t fo;
    bit        was_second;
    int        n_busy;
    n_busy     = 0;
    was_second = second_m;
    start_phase(1'b0);
    o_proj         <= rand_lanes();
    z0             <= rand_lanes();
    weight         <= rand_lanes();
    buffer_norm_in <= rand_lanes();
    for (int c = 0; c <= 20; c++) begin
        if (c > 0) begin
            @(posedge clk);
        end
        fo = rand_lanes();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (force_root && c == 12) begin
                fo[i*ROW_LANES + 7] = roots[i]; // becomes psum of the row
            end
        end
        fma_out <= fo;
        @(negedge clk);
        n_busy += busy;
        for (int l = 0; l < NUM_LANES; l++) begin
            check_req(tag, c, l, fma_req[l], resid_expect(c, l));
        end
        check_bit({tag, " scaled_x_valid"}, scaled_x_valid, c == 6);
        check_bit({tag, " rms_result_valid"}, rms_result_valid, c == 20 && was_second);
        if (c == 6 || c == 20) begin
            buffer_check(tag);
        end
        case (c)
            2: res_m = fo;
            5: buf_m.upper = fo;
            12: for (int i = 0; i < NUM_ROWS; i++) psum_m[i] = fo[i*ROW_LANES + 7];
            19: begin
                if (was_second) begin
                    buf_m.upper = fo;
                end else begin
                    buf_m.lower = fo;
                end
            end
            default: ;
        endcase
    end
    second_m = !second_m;
    wait_idle(tag, n_busy, 21);
endtask

task automatic rsqrt_pass(input string tag);
    lane_vec_t fo;
    int_vec_t  ip;
    int        n_busy;
    n_busy = 0;
    start_phase(1'b1);
    for (int c = 0; c <= 3; c++) begin
        if (c > 0) begin
            @(posedge clk);
        end
        fo = rand_lanes();
        for (int l = 0; l < NUM_LANES; l++) begin
            ip[l] = 9'($random(rng_seed));
        end
        fma_out  <= fo;
        int_part <= ip;
        @(negedge clk);
        n_busy += busy;
        for (int l = 0; l < NUM_LANES; l++) begin
            check_req(tag, c, l, fma_req[l], rsqrt_expect(c, l));
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (c == 2) begin
                alpha_exp_m[i] = ip[i*ROW_LANES][EXP_W-1:0];
                psum_m[i]      = '0;
            end else if (c == 3) begin
                alpha_m[i] = {alpha_exp_m[i], fo[i*ROW_LANES].mantissa};
            end
        end
    end
    wait_idle(tag, n_busy, 4);
endtask

task automatic idle_after_reset();
    @(negedge clk);
    check_bit("busy after reset", busy, 1'b0);
    check_bit("scaled_x_valid after reset", scaled_x_valid, 1'b0);
    check_bit("rms_result_valid after reset", rms_result_valid, 1'b0);
    for (int l = 0; l < NUM_LANES; l++) begin
        check_req("after reset", 0, l, fma_req[l], '0);
    end
endtask

task automatic busy_window();
    resid_pass("busy window", 1'b0, '0);
    rsqrt_pass("busy window rsqrt");
endtask

task automatic front_end_routing();
    resid_pass("front end", 1'b0, '0);
endtask

task automatic scaled_x_capture();
    resid_pass("scaled x", 1'b0, '0);
endtask

task automatic reduction_and_psum();
    row_vec_t roots;
    for (int i = 0; i < NUM_ROWS; i++) begin
        roots[i] = 17'($random(rng_seed));
    end
    resid_pass("reduction", 1'b1, roots);
    resid_pass("psum reuse", 1'b0, '0);
endtask

task automatic seed_operands();
    row_vec_t roots;
    roots[0] = {8'h81, 9'h080}; // odd exponent with mantissa one
    roots[1] = {8'h7f, 9'h0a0};
    roots[2] = {8'h83, 9'h0f0};
    roots[3] = {8'h80, 9'h0b3}; // even and just below the knee
    roots[4] = {8'h7e, 9'h0b4};
    roots[5] = {8'h82, 9'h080};
    roots[6] = 17'($random(rng_seed));
    roots[7] = 17'($random(rng_seed));
    resid_pass("seed load", 1'b1, roots);
    rsqrt_pass("seed operands");
endtask

task automatic alpha_and_buffer();
    rsqrt_pass("alpha load");
    resid_pass("alpha pass a", 1'b0, '0);
    resid_pass("alpha pass b", 1'b0, '0);
endtask

/* bench/tb_post_attn_norm_ctrl.sv */
// directed testbench; fma_out and int_part stand in for the FMA array, the run ends at a cycle limit
module tb_post_attn_norm_ctrl;
    import norm_pkg::*;

    localparam int RESID_CYCLES   = 24; // start pulse, counts 0..20, idle check
    localparam int RSQRT_CYCLES   = 7;
    localparam int TEST_CYCLES    = 8 * RESID_CYCLES + 3 * RSQRT_CYCLES + 8;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic       clk;
    logic       rst_n;
    logic       start_residual;
    logic       start_rsqrt;
    lane_vec_t  o_proj;
    lane_vec_t  z0;
    lane_vec_t  weight;
    lane_vec_t  fma_out;
    int_vec_t   int_part;
    lane_vec_t  buffer_norm_in;
    logic       busy;
    fma_req_t   fma_req;
    norm_buf_t  buffer_norm_out;
    logic       scaled_x_valid;
    logic       rms_result_valid;

    // expected state, updated from the step tables as the passes run
    lane_vec_t        res_m;
    row_vec_t         psum_m = '0;
    row_vec_t         alpha_m = '0;
    logic [EXP_W-1:0] alpha_exp_m [NUM_ROWS];
    norm_buf_t        buf_m;
    bit               second_m = 1'b0;

    integer rng_seed = 71705;
    int     req_errs;
    int     val_errs;
    int     bit_errs;
    int     other_errs;
    int     cycles;

    post_attn_norm_ctrl uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_residual   (start_residual),
        .start_rsqrt      (start_rsqrt),
        .o_proj           (o_proj),
        .z0               (z0),
        .weight           (weight),
        .fma_out          (fma_out),
        .int_part         (int_part),
        .buffer_norm_in   (buffer_norm_in),
        .busy             (busy),
        .fma_req          (fma_req),
        .buffer_norm_out  (buffer_norm_out),
        .scaled_x_valid   (scaled_x_valid),
        .rms_result_valid (rms_result_valid)
    );

    `include "tb_norm_checks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        rst_n          = 1'b0;
        start_residual = 1'b0;
        start_rsqrt    = 1'b0;
        o_proj         = '0;
        z0             = '0;
        weight         = '0;
        fma_out        = '0;
        int_part       = '0;
        buffer_norm_in = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        idle_after_reset();
        busy_window();
        front_end_routing();
        scaled_x_capture();
        reduction_and_psum();
        seed_operands();
        alpha_and_buffer();

        $display("errors: %0d request, %0d value, %0d level, %0d other",
                 req_errs, val_errs, bit_errs, other_errs);
        if (req_errs + val_errs + bit_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* hw/post_attn_norm_ctrl.sv */
// drives a fixed-latency 8x8 FMA array; results are sampled blindly at fixed counts
module post_attn_norm_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_residual,
    input  logic                 start_rsqrt,
    input  norm_pkg::lane_vec_t  o_proj,
    input  norm_pkg::lane_vec_t  z0,
    input  norm_pkg::lane_vec_t  weight,          // only row 0 is used
    input  norm_pkg::lane_vec_t  fma_out,
    input  norm_pkg::int_vec_t   int_part,
    input  norm_pkg::lane_vec_t  buffer_norm_in,
    output logic                 busy,
    output norm_pkg::fma_req_t   fma_req,
    output norm_pkg::norm_buf_t  buffer_norm_out,
    output logic                 scaled_x_valid,
    output logic                 rms_result_valid
);
    import norm_pkg::*;

    norm_step_t  step;
    row_vec_t    psum;
    row_vec_t    alpha;
    lane_vec_t   residual_reg;
    rsqrt_seed_t [NUM_ROWS-1:0] seed;

    norm_seq u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_residual (start_residual),
        .start_rsqrt    (start_rsqrt),
        .step           (step),
        .busy           (busy)
    );

    rsqrt_seed_sel u_seed_sel (
        .psum (psum),
        .seed (seed)
    );

    norm_operand_sel u_operand_sel (
        .step           (step),
        .o_proj         (o_proj),
        .z0             (z0),
        .weight         (weight),
        .fma_out        (fma_out),
        .buffer_norm_in (buffer_norm_in),
        .residual_reg   (residual_reg),
        .psum           (psum),
        .alpha          (alpha),
        .seed           (seed),
        .fma_req        (fma_req)
    );

    norm_result_capture u_capture (
        .clk              (clk),
        .rst_n            (rst_n),
        .step             (step),
        .fma_out          (fma_out),
        .int_part         (int_part),
        .residual_reg     (residual_reg),
        .psum             (psum),
        .alpha            (alpha),
        .buffer_norm_out  (buffer_norm_out),
        .scaled_x_valid   (scaled_x_valid),
        .rms_result_valid (rms_result_valid)
    );

endmodule

/* hw/norm_result_capture.sv */
// samples fma_out at fixed counts with no handshake; array latency must match the step table
module norm_result_capture (
    input  logic                 clk,
    input  logic                 rst_n,
    input  norm_pkg::norm_step_t step,
    input  norm_pkg::lane_vec_t  fma_out,
    input  norm_pkg::int_vec_t   int_part,
    output norm_pkg::lane_vec_t  residual_reg,
    output norm_pkg::row_vec_t   psum,
    output norm_pkg::row_vec_t   alpha,
    output norm_pkg::norm_buf_t  buffer_norm_out,
    output logic                 scaled_x_valid,
    output logic                 rms_result_valid
);
    import norm_pkg::*;

    logic [EXP_W-1:0] alpha_exp [NUM_ROWS];
    logic             second_pass; // toggles every count-19 capture

    logic cap_residual;
    logic cap_scaled;
    logic cap_psum;
    logic cap_final;
    logic cap_exp;
    logic cap_alpha;

    assign cap_residual = (step.phase == PH_RESID) && (step.cnt == 5'd2);
    assign cap_scaled   = (step.phase == PH_RESID) && (step.cnt == 5'd5);
    assign cap_psum     = (step.phase == PH_RESID) && (step.cnt == 5'd12);
    assign cap_final    = (step.phase == PH_RESID) && (step.cnt == 5'd19);
    assign cap_exp      = (step.phase == PH_RSQRT) && (step.cnt == 5'd2);
    assign cap_alpha    = (step.phase == PH_RSQRT) && (step.cnt == 5'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            second_pass      <= 1'b0;
            scaled_x_valid   <= 1'b0;
            rms_result_valid <= 1'b0;
            psum             <= '0;
            alpha            <= '0;
        end else begin
            scaled_x_valid   <= cap_scaled;              // high during count 6
            rms_result_valid <= cap_final && second_pass; // high during count 20
            if (cap_final) begin
                second_pass <= !second_pass;
            end
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (cap_psum) begin
                    psum[i] <= fma_out[i*ROW_LANES + ROW_LANES-1]; // tree root sits in lane 7
                end else if (cap_exp) begin
                    psum[i] <= '0; // consumed by the seed, start a fresh sum
                end
                if (cap_alpha) begin
                    alpha[i] <= {alpha_exp[i], fma_out[i*ROW_LANES].mantissa};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_residual) begin
            residual_reg <= fma_out;
        end
        if (cap_scaled || (cap_final && second_pass)) begin
            buffer_norm_out.upper <= fma_out;
        end
        if (cap_final && !second_pass) begin
            buffer_norm_out.lower <= fma_out;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (cap_exp) begin
                alpha_exp[i] <= int_part[i*ROW_LANES][EXP_W-1:0]; // integer part from lane 8i
            end
        end
    end

endmodule

/* hw/norm_operand_sel.sv */
// combinational from the step; lanes a step does not name get OP_NONE and zero operands
module norm_operand_sel (
    input  norm_pkg::norm_step_t                         step,
    input  norm_pkg::lane_vec_t                          o_proj,
    input  norm_pkg::lane_vec_t                          z0,
    input  norm_pkg::lane_vec_t                          weight,
    input  norm_pkg::lane_vec_t                          fma_out,
    input  norm_pkg::lane_vec_t                          buffer_norm_in,
    input  norm_pkg::lane_vec_t                          residual_reg,
    input  norm_pkg::row_vec_t                           psum,
    input  norm_pkg::row_vec_t                           alpha,
    input  norm_pkg::rsqrt_seed_t [norm_pkg::NUM_ROWS-1:0] seed,
    output norm_pkg::fma_req_t                           fma_req
);
    import norm_pkg::*;

    function automatic fma_lane_t make_lane(fma_op_e op, fp_t a, fp_t b, fp_t c);
        fma_lane_t lane;
        lane.op = op;
        lane.a  = a;
        lane.b  = b;
        lane.c  = c;
        return lane;
    endfunction

    always_comb begin
        int base;
        int src_base;
        fma_req = '0;
        case (step.phase)
            PH_RESID: begin
                for (int i = 0; i < NUM_ROWS; i++) begin
                    base = i * ROW_LANES;
                    case (step.cnt)
                        5'd0: for (int j = 0; j < ROW_LANES; j++) begin // residual add
                            fma_req[base+j] = make_lane(OP_ADD, o_proj[base+j], '0,
                                                        z0[base+j]);
                        end
                        5'd2: for (int j = 0; j < ROW_LANES; j++) begin // x^2
                            fma_req[base+j] = make_lane(OP_MUL, fma_out[base+j],
                                                        fma_out[base+j], '0);
                        end
                        5'd3: for (int j = 0; j < ROW_LANES; j++) begin
                            // row 0 weights broadcast to every row
                            fma_req[base+j] = make_lane(OP_MUL, residual_reg[base+j],
                                                        weight[j], '0);
                        end
                        5'd4, 5'd6, 5'd8: begin
                            // halving tree: sources start at 0, 4, 6 and results land above them
                            src_base = ROW_LANES - (ROW_LANES >> ((int'(step.cnt) - 4) / 2));
                            for (int k = 0; k < ROW_LANES / 2; k++) begin
                                if (k < (ROW_LANES - src_base) / 2) begin
                                    fma_req[base + ROW_LANES/2 + src_base/2 + k] =
                                        make_lane(OP_ADD, fma_out[base + src_base + 2*k + 1],
                                                  '0, fma_out[base + src_base + 2*k]);
                                end
                            end
                        end
                        5'd10: begin // fold in the running partial sum
                            fma_req[base+ROW_LANES-1] = make_lane(OP_ADD,
                                fma_out[base+ROW_LANES-1], '0, psum[i]);
                        end
                        5'd17: for (int j = 0; j < ROW_LANES; j++) begin // scale by alpha
                            fma_req[base+j] = make_lane(OP_MUL, alpha[i],
                                                        buffer_norm_in[base+j], '0);
                        end
                        default: ;
                    endcase
                end
            end
            PH_RSQRT: begin
                for (int i = 0; i < NUM_ROWS; i++) begin
                    base = i * ROW_LANES;
                    if (step.cnt == 5'd0) begin
                        fma_req[base] = make_lane(OP_SUB, seed[i].sub_a, '0, seed[i].sub_c);
                    end else if (step.cnt == 5'd1) begin
                        fma_req[base] = make_lane(OP_FMA, seed[i].fma_a, seed[i].fma_b,
                                                  seed[i].fma_c);
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* hw/rsqrt_seed_sel.sv */
// pure lookup on each row's partial sum; operands are only meaningful once psum holds a sum
module rsqrt_seed_sel (
    input  norm_pkg::row_vec_t                           psum,
    output norm_pkg::rsqrt_seed_t [norm_pkg::NUM_ROWS-1:0] seed
);
    import norm_pkg::*;

    logic [NUM_ROWS-1:0] odd_exp;
    logic [NUM_ROWS-1:0] man_one;
    logic [NUM_ROWS-1:0] man_low;

    always_comb begin
        for (int i = 0; i < NUM_ROWS; i++) begin
            odd_exp[i] = psum[i].exponent[0];
            man_one[i] = (psum[i].mantissa == RSQRT_MAN_ONE);
            man_low[i] = (psum[i].mantissa < RSQRT_MAN_KNEE);

            // halved exponent goes into the mantissa field, scaled by 2^7
            seed[i].sub_a.exponent = RSQRT_SUB_EXP;
            seed[i].sub_a.mantissa = {psum[i].exponent, 1'b0};

            seed[i].sub_c = odd_exp[i] ? (man_one[i] ? RSQRT_SUB_C_ODD_ONE : RSQRT_SUB_C_ODD)
                                       : RSQRT_SUB_C_EVEN;

            // segment slope
            if (odd_exp[i]) begin
                seed[i].fma_a = man_one[i] ? RSQRT_FMA_A_ODD_ONE :
                                man_low[i] ? RSQRT_FMA_A_ODD_LO  : RSQRT_FMA_A_ODD_HI;
                seed[i].fma_c = man_one[i] ? RSQRT_FMA_C_ODD_ONE :
                                man_low[i] ? RSQRT_FMA_C_ODD_LO  : RSQRT_FMA_C_ODD_HI;
            end else begin
                seed[i].fma_a = man_low[i] ? RSQRT_FMA_A_EVEN_LO : RSQRT_FMA_A_EVEN_HI;
                seed[i].fma_c = man_low[i] ? RSQRT_FMA_C_EVEN_LO : RSQRT_FMA_C_EVEN_HI;
            end

            seed[i].fma_b.exponent = '0; // bare mantissa as the segment input
            seed[i].fma_b.mantissa = psum[i].mantissa;
        end
    end

endmodule

/* hw/norm_seq.sv */
// a start pulse while busy restarts the count; start_residual wins over start_rsqrt
module norm_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_residual,
    input  logic                 start_rsqrt,
    output norm_pkg::norm_step_t step,
    output logic                 busy
);
    import norm_pkg::*;

    norm_phase_e phase;
    step_t       cnt;
    logic        last_step;

    // final count of whichever phase is running
    assign last_step = ((phase == PH_RESID) && (cnt == RESID_LAST_STEP)) ||
                       ((phase == PH_RSQRT) && (cnt == RSQRT_LAST_STEP));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            cnt   <= '0;
        end else if (start_residual) begin
            phase <= PH_RESID;
            cnt   <= '0;
        end else if (start_rsqrt) begin
            phase <= PH_RSQRT;
            cnt   <= '0;
        end else if (last_step) begin
            phase <= PH_IDLE; // busy drops at this edge
            cnt   <= '0;
        end else if (phase != PH_IDLE) begin
            cnt <= cnt + 5'd1;
        end
    end

    assign step.phase = phase;
    assign step.cnt   = cnt;
    assign busy       = (phase != PH_IDLE);

endmodule

/* hw/norm_pkg.sv */
// fixed 8x8 prefill schedule only; no decode mode, every size and seed constant is set here
package norm_pkg;

    localparam int EXP_W = 8;
    localparam int MAN_W = 9;
    localparam int FP_W  = EXP_W + MAN_W;

    localparam int NUM_ROWS  = 8;
    localparam int ROW_LANES = 8;
    localparam int NUM_LANES = NUM_ROWS * ROW_LANES;

    typedef logic [4:0] step_t;

    localparam step_t RESID_LAST_STEP = 5'd20;
    localparam step_t RSQRT_LAST_STEP = 5'd3;

    typedef struct packed {
        logic [EXP_W-1:0] exponent;
        logic [MAN_W-1:0] mantissa;
    } fp_t;

    // one-hot lane opcodes as the FMA array expects them
    typedef enum logic [4:0] {
        OP_NONE = 5'd0,
        OP_SUB  = 5'd1,
        OP_MUL  = 5'd2,
        OP_FMA  = 5'd4,
        OP_ADD  = 5'd8
    } fma_op_e;

    typedef struct packed {
        fma_op_e op;
        fp_t     a;
        fp_t     b;
        fp_t     c;
    } fma_lane_t;

    typedef fma_lane_t [NUM_LANES-1:0]      fma_req_t;
    typedef fp_t [NUM_LANES-1:0]            lane_vec_t;
    typedef logic [NUM_LANES-1:0][MAN_W-1:0] int_vec_t;
    typedef fp_t [NUM_ROWS-1:0]             row_vec_t;

    typedef struct packed {
        lane_vec_t upper; // scaled x, then second half of the normalized result
        lane_vec_t lower;
    } norm_buf_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_RESID,
        PH_RSQRT
    } norm_phase_e;

    typedef struct packed {
        norm_phase_e phase;
        step_t       cnt;
    } norm_step_t;

    typedef struct packed {
        fp_t sub_a;
        fp_t sub_c;
        fp_t fma_a;
        fp_t fma_b;
        fp_t fma_c;
    } rsqrt_seed_t;

    // piecewise-linear 1/sqrt segments, split on exponent parity and mantissa knee
    localparam logic [EXP_W-1:0] RSQRT_SUB_EXP  = 8'd7;
    localparam logic [MAN_W-1:0] RSQRT_MAN_ONE  = 9'h080;
    localparam logic [MAN_W-1:0] RSQRT_MAN_KNEE = 9'h0b4;

    localparam logic [FP_W-1:0] RSQRT_SUB_C_ODD_ONE = 17'h00a88; // 8.5
    localparam logic [FP_W-1:0] RSQRT_SUB_C_ODD     = 17'h008f0; // 7.5
    localparam logic [FP_W-1:0] RSQRT_SUB_C_EVEN    = 17'h00a80; // 8

    localparam logic [FP_W-1:0] RSQRT_FMA_A_ODD_ONE = 17'h00480;
    localparam logic [FP_W-1:0] RSQRT_FMA_A_ODD_LO  = 17'h0073c;
    localparam logic [FP_W-1:0] RSQRT_FMA_A_ODD_HI  = 17'h00518;
    localparam logic [FP_W-1:0] RSQRT_FMA_A_EVEN_LO = 17'h00976;
    localparam logic [FP_W-1:0] RSQRT_FMA_A_EVEN_HI = 17'h0075c;

    localparam logic [FP_W-1:0] RSQRT_FMA_C_ODD_ONE = 17'h00000;
    localparam logic [FP_W-1:0] RSQRT_FMA_C_ODD_LO  = 17'h006b0;
    localparam logic [FP_W-1:0] RSQRT_FMA_C_ODD_HI  = 17'h00694;
    localparam logic [FP_W-1:0] RSQRT_FMA_C_EVEN_LO = 17'h006f8;
    localparam logic [FP_W-1:0] RSQRT_FMA_C_EVEN_HI = 17'h006d1;

endpackage
